// File: hdl/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and instruction word width
`define WORD_W 16

// program and data address width
`define ADDR_W 12

// program memory words
// one per address, pc wraps at the top
`define PMEM_DEPTH 4096

// data memory words
`define DMEM_DEPTH 4096

// instruction queue entries
// nearly_full trips with one entry left
`define IQ_DEPTH 4

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // basic data and address words
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // arithmetic unit operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_DIV  = 4'd3,
        ALU_SHL  = 4'd4,
        ALU_SHR  = 4'd5,
        ALU_ROL  = 4'd6,
        ALU_ROR  = 4'd7,
        ALU_AND  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_NOR  = 4'd11,
        ALU_NAND = 4'd12,
        ALU_XNOR = 4'd13,
        ALU_GT   = 4'd14,
        ALU_EQ   = 4'd15
    } alu_op_t;

    // memory and branch operations
    // codes 5 to 7 all behave as no-op
    typedef enum logic [2:0] {
        MEM_LOAD  = 3'd0,
        MEM_STORE = 3'd1,
        MEM_JMP   = 3'd2,
        MEM_JZ    = 3'd3,
        MEM_HALT  = 3'd4,
        MEM_NOP   = 3'd5
    } mem_op_t;

    // kind 0 means acc op imm
    typedef struct packed {
        logic       kind;
        alu_op_t    op;
        logic [10:0] imm;
    } alu_instr_t;

    // kind 1 means memory access or branch
    typedef struct packed {
        logic    kind;
        mem_op_t op;
        addr_t   addr;
    } mem_instr_t;

    // one instruction word seen two ways
    // kind bit sits at 15 in both
    typedef union packed {
        alu_instr_t alu;
        mem_instr_t mem;
    } instr_u;

endpackage

// File: hdl/iq_if.sv
// link between fetch, instruction queue and execute
interface iq_if;

    // fetch side
    logic            push;
    cpu_pkg::word_t  push_word;

    // execute side
    logic            pop;
    logic            flush;

    // queue status
    cpu_pkg::word_t  head_word;
    logic            empty;
    logic            nearly_full;

    // fetch unit
    modport producer (output push, output push_word, input nearly_full);

    // queue itself
    modport buffer (
        input  push, push_word, pop, flush,
        output head_word, empty, nearly_full
    );

    // execute unit
    modport consumer (output pop, output flush, input head_word, input empty);

endinterface

// File: hdl/fetch_unit.sv
`include "cpu_defs.svh"

module fetch_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           prog_we,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    input  logic           redirect,
    input  cpu_pkg::addr_t redirect_pc,
    iq_if.producer         iq
);

    // program memory, loaded while run is low
    cpu_pkg::word_t pmem [`PMEM_DEPTH];

    cpu_pkg::addr_t pc;
    // one read in flight at most
    logic           rd_valid;
    cpu_pkg::word_t rd_word;
    logic           issue;

    // no new address during redirect, pc is being replaced
    // stop on nearly_full, the read in flight still has room
    assign issue = run && !iq.nearly_full && !redirect;

    // load port and synchronous read
    always_ff @(posedge clk) begin
        if (prog_we) begin
            pmem[prog_addr] <= prog_data;
        end
        if (issue) begin
            rd_word <= pmem[pc];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            rd_valid <= 1'b0;
        end else begin
            // redirect drops whatever was issued this cycle
            rd_valid <= issue;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (issue) begin
                // wraps from top address to 0
                pc <= pc + cpu_pkg::addr_t'(1);
            end
        end
    end

    // word answered one cycle after issue
    // stale word from before the redirect is not pushed
    assign iq.push      = rd_valid && !redirect;
    assign iq.push_word = rd_word;

endmodule

// File: hdl/instr_queue.sv
`include "cpu_defs.svh"

module instr_queue (
    input  logic   clk,
    input  logic   rst,
    iq_if.buffer   iq
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    cpu_pkg::word_t    mem [`IQ_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // explicit wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(`IQ_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + PTR_W'(1);
        end
        return nxt;
    endfunction

    // entry storage, push dropped on flush
    always_ff @(posedge clk) begin
        if (iq.push && !iq.flush) begin
            mem[wr_ptr] <= iq.push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || iq.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (iq.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (iq.pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves count alone
            case ({iq.push, iq.pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    assign iq.head_word   = mem[rd_ptr];
    assign iq.empty       = (count == '0);
    // one or no free entry left
    assign iq.nearly_full = (count >= CNT_W'(`IQ_DEPTH - 1));

endmodule

// File: hdl/exec_unit.sv
`include "cpu_defs.svh"

module exec_unit (
    input  logic           clk,
    input  logic           rst,
    iq_if.consumer         iq,
    output logic           redirect,
    output cpu_pkg::addr_t redirect_pc,
    output cpu_pkg::word_t acc,
    output logic           halted,
    output logic           store_strobe,
    output cpu_pkg::addr_t store_addr,
    output cpu_pkg::word_t store_data
);

    // data memory
    cpu_pkg::word_t dmem [`DMEM_DEPTH];
    cpu_pkg::word_t dmem_q;

    cpu_pkg::instr_u instr;
    cpu_pkg::word_t  operand;
    cpu_pkg::word_t  alu_res;
    // second cycle of a load
    logic            load_wait;
    logic            pop;
    logic            is_alu;
    logic            is_load;
    logic            is_store;
    logic            is_jump;
    logic            is_halt;

    // sixteen-op arithmetic unit
    function automatic cpu_pkg::word_t alu_calc(
        input cpu_pkg::alu_op_t op,
        input cpu_pkg::word_t   a,
        input cpu_pkg::word_t   b
    );
        cpu_pkg::word_t r;
        case (op)
            cpu_pkg::ALU_ADD:  r = a + b;
            cpu_pkg::ALU_SUB:  r = a - b;
            // low half of the product only
            cpu_pkg::ALU_MUL:  r = a * b;
            cpu_pkg::ALU_DIV:  r = (b == '0) ? '1 : a / b;
            // shifts and rotates work on acc alone
            cpu_pkg::ALU_SHL:  r = a << 1;
            cpu_pkg::ALU_SHR:  r = a >> 1;
            cpu_pkg::ALU_ROL:  r = {a[`WORD_W-2:0], a[`WORD_W-1]};
            cpu_pkg::ALU_ROR:  r = {a[0], a[`WORD_W-1:1]};
            cpu_pkg::ALU_AND:  r = a & b;
            cpu_pkg::ALU_OR:   r = a | b;
            cpu_pkg::ALU_XOR:  r = a ^ b;
            cpu_pkg::ALU_NOR:  r = ~(a | b);
            cpu_pkg::ALU_NAND: r = ~(a & b);
            cpu_pkg::ALU_XNOR: r = ~(a ^ b);
            cpu_pkg::ALU_GT:   r = cpu_pkg::word_t'(a > b);
            default:           r = cpu_pkg::word_t'(a == b);
        endcase
        return r;
    endfunction

    assign instr   = iq.head_word;
    // immediate zero-extended to a full word
    assign operand = cpu_pkg::word_t'(instr.alu.imm);
    assign alu_res = alu_calc(instr.alu.op, acc, operand);

    // head word decode
    always_comb begin
        is_alu   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_jump  = 1'b0;
        is_halt  = 1'b0;
        if (instr.alu.kind == 1'b0) begin
            is_alu = 1'b1;
        end else begin
            case (instr.mem.op)
                cpu_pkg::MEM_LOAD:  is_load  = 1'b1;
                cpu_pkg::MEM_STORE: is_store = 1'b1;
                cpu_pkg::MEM_JMP:   is_jump  = 1'b1;
                // zero test on acc as it stands now
                cpu_pkg::MEM_JZ:    is_jump  = (acc == '0);
                cpu_pkg::MEM_HALT:  is_halt  = 1'b1;
                cpu_pkg::MEM_NOP:   ;
                default:            ;
            endcase
        end
    end

    // no pop during load writeback or after halt
    assign pop      = !iq.empty && !halted && !load_wait;
    assign iq.pop   = pop;

    // taken branch also clears the queue
    assign redirect    = pop && is_jump;
    assign redirect_pc = instr.mem.addr;
    assign iq.flush    = redirect;

    assign store_strobe = pop && is_store;
    assign store_addr   = instr.mem.addr;
    assign store_data   = acc;

    // store writes, load reads, both in the pop cycle
    always_ff @(posedge clk) begin
        if (store_strobe) begin
            dmem[instr.mem.addr] <= acc;
        end
        if (pop && is_load) begin
            dmem_q <= dmem[instr.mem.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc       <= '0;
            halted    <= 1'b0;
            load_wait <= 1'b0;
        end else begin
            load_wait <= pop && is_load;
            if (load_wait) begin
                acc <= dmem_q;
            end else if (pop && is_alu) begin
                acc <= alu_res;
            end
            // sticky until reset
            if (pop && is_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/acc_cpu_top.sv
module acc_cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           prog_we,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    output cpu_pkg::word_t acc,
    output logic           halted,
    output logic           store_strobe,
    output cpu_pkg::addr_t store_addr,
    output cpu_pkg::word_t store_data
);

    // branch target path, execute back to fetch
    logic           redirect;
    cpu_pkg::addr_t redirect_pc;

    iq_if iq ();

    // pc and program memory
    fetch_unit fetch_unit_i (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .iq          (iq.producer)
    );

    instr_queue instr_queue_i (
        .clk (clk),
        .rst (rst),
        .iq  (iq.buffer)
    );

    // alu, acc and data memory
    exec_unit exec_unit_i (
        .clk          (clk),
        .rst          (rst),
        .iq           (iq.consumer),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .acc          (acc),
        .halted       (halted),
        .store_strobe (store_strobe),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

endmodule

// File: test/acc_cpu_properties.sv
// queue and execute protocol rules
module acc_cpu_properties (
    input logic clk,
    input logic rst,
    input logic pop,
    input logic empty,
    input logic halted,
    input logic store_strobe,
    input logic push,
    input logic full
);

    // execute only takes a head that exists
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("pop while queue empty");

    // halt is sticky, only reset clears it
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        ($past(halted) && !$past(rst)) |-> halted)
        else $error("halted dropped without reset");

    a_no_store_halted: assert property (@(posedge clk) disable iff (rst)
        halted |-> !store_strobe)
        else $error("store strobe after halt");

    // in-flight read must always find room
    a_no_push_full: assert property (@(posedge clk) disable iff (rst) full |-> !push)
        else $error("push into full queue");

endmodule

bind exec_unit acc_cpu_properties exec_props_i (
    .clk          (clk),
    .rst          (rst),
    .pop          (pop),
    .empty        (iq.empty),
    .halted       (halted),
    .store_strobe (store_strobe),
    .push         (1'b0),
    .full         (1'b0)
);

// full is equal pointers with something stored
bind instr_queue acc_cpu_properties queue_props_i (
    .clk          (clk),
    .rst          (rst),
    .pop          (iq.pop),
    .empty        (iq.empty),
    .halted       (1'b0),
    .store_strobe (1'b0),
    .push         (iq.push),
    .full         (!iq.empty && (wr_ptr == rd_ptr))
);

// File: test/acc_cpu_tb.sv
`include "cpu_defs.svh"

module acc_cpu_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic           clk;
    logic           rst;
    logic           run;
    logic           prog_we;
    cpu_pkg::addr_t prog_addr;
    cpu_pkg::word_t prog_data;
    cpu_pkg::word_t acc;
    logic           halted;
    logic           store_strobe;
    cpu_pkg::addr_t store_addr;
    cpu_pkg::word_t store_data;

    logic [31:0]    seed   = 32'h8a6e_2d39;

    // program under test and the model's view of it
    cpu_pkg::word_t prog [$];
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    cpu_pkg::word_t exp_acc;
    cpu_pkg::word_t ref_mem [`DMEM_DEPTH];
    // stores seen at the dut outputs
    cpu_pkg::addr_t got_addr [$];
    cpu_pkg::word_t got_data [$];

    acc_cpu_top acc_cpu_top_i (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .acc          (acc),
        .halted       (halted),
        .store_strobe (store_strobe),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // strobe is one cycle wide
    // mid-cycle sample sees each store once
    always @(negedge clk) begin
        if (store_strobe) begin
            got_addr.push_back(store_addr);
            got_data.push_back(store_data);
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // instruction encoders
    function automatic cpu_pkg::word_t alu_word(input cpu_pkg::alu_op_t op,
                                                input logic [10:0] imm);
        cpu_pkg::instr_u w;
        w.alu.kind = 1'b0;
        w.alu.op   = op;
        w.alu.imm  = imm;
        return w;
    endfunction

    function automatic cpu_pkg::word_t mem_word(input cpu_pkg::mem_op_t op,
                                                input cpu_pkg::addr_t addr);
        cpu_pkg::instr_u w;
        w.mem.kind = 1'b1;
        w.mem.op   = op;
        w.mem.addr = addr;
        return w;
    endfunction

    // expected arithmetic result
    // b is the zero-extended immediate
    function automatic cpu_pkg::word_t model_alu(input cpu_pkg::alu_op_t op,
                                                 input cpu_pkg::word_t a,
                                                 input cpu_pkg::word_t b);
        cpu_pkg::word_t r;
        case (op)
            cpu_pkg::ALU_ADD:  r = a + b;
            cpu_pkg::ALU_SUB:  r = a - b;
            // 16-bit context keeps the low half
            cpu_pkg::ALU_MUL:  r = a * b;
            cpu_pkg::ALU_DIV:  r = (b == 16'd0) ? 16'hffff : a / b;
            cpu_pkg::ALU_SHL:  r = {a[14:0], 1'b0};
            cpu_pkg::ALU_SHR:  r = {1'b0, a[15:1]};
            cpu_pkg::ALU_ROL:  r = (a << 1) | (a >> 15);
            cpu_pkg::ALU_ROR:  r = (a >> 1) | (a << 15);
            cpu_pkg::ALU_AND:  r = a & b;
            cpu_pkg::ALU_OR:   r = a | b;
            cpu_pkg::ALU_XOR:  r = a ^ b;
            cpu_pkg::ALU_NOR:  r = ~a & ~b;
            cpu_pkg::ALU_NAND: r = ~a | ~b;
            cpu_pkg::ALU_XNOR: r = a ^ ~b;
            cpu_pkg::ALU_GT:   r = (a > b) ? 16'd1 : 16'd0;
            default:           r = (a == b) ? 16'd1 : 16'd0;
        endcase
        return r;
    endfunction

    // walk the program in order one instruction at a time
    task automatic run_model();
        cpu_pkg::instr_u ins;
        int              pc;
        int              steps;
        logic            done;
        pc      = 0;
        steps   = 0;
        done    = 1'b0;
        exp_acc = '0;
        exp_addr.delete();
        exp_data.delete();
        while (!done && steps < 1000) begin
            ins = prog[pc];
            pc++;
            steps++;
            if (!ins.alu.kind) begin
                exp_acc = model_alu(ins.alu.op, exp_acc, {5'd0, ins.alu.imm});
            end else begin
                case (ins.mem.op)
                    cpu_pkg::MEM_LOAD:  exp_acc = ref_mem[ins.mem.addr];
                    cpu_pkg::MEM_STORE: begin
                        ref_mem[ins.mem.addr] = exp_acc;
                        exp_addr.push_back(ins.mem.addr);
                        exp_data.push_back(exp_acc);
                    end
                    cpu_pkg::MEM_JMP:   pc = int'(ins.mem.addr);
                    cpu_pkg::MEM_JZ: begin
                        if (exp_acc == 16'd0) begin
                            pc = int'(ins.mem.addr);
                        end
                    end
                    cpu_pkg::MEM_HALT:  done = 1'b1;
                    default:            ;
                endcase
            end
        end
    endtask

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t got);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t exp,
                              input cpu_pkg::addr_t got);
        if (got !== exp) begin
            $display("FAILED %s: expected address %h, actual %h", name, exp, got);
            stop_run();
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        next_cycle();
        rst = 1'b1;
        run = 1'b0;
        repeat (10) begin
            next_cycle();
        end
        rst = 1'b0;
    endtask

    // load, run to halt, hold 20 cycles, compare, reset
    task automatic run_prog(input string name);
        run_model();
        got_addr.delete();
        got_data.delete();
        for (int i = 0; i < prog.size(); i++) begin
            prog_we   = 1'b1;
            prog_addr = cpu_pkg::addr_t'(i);
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
        run     = 1'b1;
        // watchdog bounds this wait
        while (!halted) begin
            @(negedge clk);
        end
        check_word({name, " acc"}, exp_acc, acc);
        repeat (20) begin
            @(negedge clk);
            check_word({name, " hold"}, exp_acc, acc);
        end
        // a stray strobe after halt shows up as an extra store
        if (got_addr.size() != exp_addr.size()) begin
            $display("FAILED %s: expected %0d stores, actual %0d",
                     name, exp_addr.size(), got_addr.size());
            stop_run();
        end
        foreach (exp_addr[k]) begin
            check_addr(name, exp_addr[k], got_addr[k]);
            check_word(name, exp_data[k], got_data[k]);
        end
        apply_reset();
    endtask

    // every op in order then ops picked by the lcg
    // acc stored after each
    task automatic test_arith();
        logic [31:0]      r;
        cpu_pkg::alu_op_t op;
        prog.delete();
        for (int i = 0; i < 32; i++) begin
            r = lcg_next();
            if (i < 16) begin
                op = cpu_pkg::alu_op_t'(4'(i));
            end else begin
                op = cpu_pkg::alu_op_t'(r[31:28]);
            end
            prog.push_back(alu_word(op, r[26:16]));
            prog.push_back(mem_word(cpu_pkg::MEM_STORE, cpu_pkg::addr_t'(12'h040 + i)));
        end
        prog.push_back(mem_word(cpu_pkg::MEM_HALT, 12'h000));
        run_prog("arith");
    endtask

    // stores at three addresses read back out of order
    task automatic test_mem();
        prog.delete();
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'h123));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h010));
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'h456));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h020));
        prog.push_back(alu_word(cpu_pkg::ALU_XOR, 11'h7ff));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h030));
        prog.push_back(mem_word(cpu_pkg::MEM_LOAD, 12'h020));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h050));
        prog.push_back(mem_word(cpu_pkg::MEM_LOAD, 12'h030));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h051));
        prog.push_back(mem_word(cpu_pkg::MEM_LOAD, 12'h010));
        prog.push_back(mem_word(cpu_pkg::MEM_HALT, 12'h000));
        run_prog("mem");
        // last load came from 0x010
        check_word("mem last load", 16'h0123, got_data[0]);
    endtask

    // skipped adds would leave acc off 7
    task automatic test_branch();
        prog.delete();
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'd5));
        prog.push_back(mem_word(cpu_pkg::MEM_JMP, 12'd3));
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'd100));
        prog.push_back(mem_word(cpu_pkg::MEM_JZ, 12'd5));
        prog.push_back(alu_word(cpu_pkg::ALU_SUB, 11'd5));
        prog.push_back(mem_word(cpu_pkg::MEM_JZ, 12'd7));
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'd200));
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'd7));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h060));
        prog.push_back(mem_word(cpu_pkg::MEM_HALT, 12'h000));
        run_prog("branch");
        check_word("branch result", 16'd7, got_data[0]);
    endtask

    // load stalls let fetch run ahead until the queue fills
    task automatic test_backpressure();
        logic [31:0] r;
        prog.delete();
        for (int k = 0; k < 4; k++) begin
            r = lcg_next();
            prog.push_back(alu_word(cpu_pkg::ALU_ADD, r[26:16]));
            prog.push_back(mem_word(cpu_pkg::MEM_STORE, cpu_pkg::addr_t'(12'h080 + k)));
        end
        for (int i = 0; i < 12; i++) begin
            r = lcg_next();
            prog.push_back(mem_word(cpu_pkg::MEM_LOAD, cpu_pkg::addr_t'(12'h080 + (i % 4))));
            prog.push_back(alu_word(cpu_pkg::ALU_ADD, r[26:16]));
            prog.push_back(mem_word(cpu_pkg::MEM_STORE, cpu_pkg::addr_t'(12'h090 + i)));
        end
        prog.push_back(mem_word(cpu_pkg::MEM_HALT, 12'h000));
        run_prog("backpressure");
    endtask

    // div by zero, rotate end bits, 16-bit product wrap
    task automatic test_corner();
        prog.delete();
        prog.push_back(alu_word(cpu_pkg::ALU_ADD, 11'h123));
        prog.push_back(alu_word(cpu_pkg::ALU_DIV, 11'h000));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h0c0));
        prog.push_back(alu_word(cpu_pkg::ALU_AND, 11'h401));
        prog.push_back(alu_word(cpu_pkg::ALU_ROR, 11'h155));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h0c1));
        prog.push_back(alu_word(cpu_pkg::ALU_ROL, 11'h2aa));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h0c2));
        prog.push_back(alu_word(cpu_pkg::ALU_MUL, 11'h7ff));
        prog.push_back(mem_word(cpu_pkg::MEM_STORE, 12'h0c3));
        prog.push_back(mem_word(cpu_pkg::MEM_HALT, 12'h000));
        run_prog("corner");
        check_word("corner div0", 16'hffff, got_data[0]);
        check_word("corner ror", 16'h8200, got_data[1]);
        check_word("corner rol", 16'h0401, got_data[2]);
        check_word("corner mul", 16'h03ff, got_data[3]);
    endtask

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        apply_reset();
        test_arith();
        test_mem();
        test_branch();
        test_backpressure();
        test_corner();
        $display("sim passed");
        $finish;
    end

    // limit scales with the number of tests
    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
        $display("sim failed");
        $fatal(1, "watchdog expired, a program never reached halt");
    end

endmodule

// File: all.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/iq_if.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/exec_unit.sv
hdl/acc_cpu_top.sv
test/acc_cpu_properties.sv
test/acc_cpu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the accumulator cpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module acc_cpu_tb -f all.f

output=$(./obj_dir/Vacc_cpu_tb 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
